// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_interconnect_tb
FILELIST  ?= core_interconnect.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== core_interconnect.f ====
rtl/bus_pkg.sv
rtl/bus_arbiter.sv
rtl/bus_router.sv
rtl/clint.sv
rtl/axi_master_port.sv
rtl/core_interconnect.sv
testbench/core_interconnect_checker.sv
testbench/core_interconnect_tb.sv

// ==== rtl/axi_master_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_master_port (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       req_valid,
    input  bus_pkg::bus_req_t          req,
    output logic                       req_ready,
    output logic                       rsp_valid,
    output bus_pkg::bus_rsp_t          rsp,
    input  logic                       rsp_ready,
    output logic                       awvalid,
    output bus_pkg::axi_addr_t         aw,
    input  logic                       awready,
    output logic                       wvalid,
    output bus_pkg::axi_w_t            w,
    input  logic                       wready,
    input  logic                       bvalid,
    input  logic [bus_pkg::RESP_W-1:0] bresp,
    output logic                       bready,
    output logic                       arvalid,
    output bus_pkg::axi_addr_t         ar,
    input  logic                       arready,
    input  logic                       rvalid,
    input  bus_pkg::axi_r_t            r,
    output logic                       rready
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,        // Waiting for a request
        ST_ADDR,        // Address and write data out
        ST_WAIT,        // Waiting for B or R
        ST_RESP         // Holding the response
    } state_t;

    state_t   state;
    bus_req_t req_q;
    logic     aw_done;      // AW handshake seen
    logic     w_done;       // W handshake seen
    logic     aw_fire;
    logic     w_fire;
    logic     b_fire;
    logic     r_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state   <= ST_ADDR;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                ST_ADDR: begin
                    if (req_q.write) begin
                        aw_done <= aw_done || aw_fire;
                        w_done  <= w_done || w_fire;
                        if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                            state <= ST_WAIT;   // Both channels taken in either order
                        end
                    end else if (arready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (b_fire || r_fire) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == ST_IDLE && req_valid) begin
            req_q <= req;
        end
        if (b_fire) begin
            rsp.rdata <= '0;                    // Write carries no data back
            rsp.resp  <= bresp;
        end else if (r_fire) begin
            rsp.rdata <= r.data;
            rsp.resp  <= r.resp;
        end
    end

    assign req_ready = state == ST_IDLE;
    assign rsp_valid = state == ST_RESP;
    assign awvalid   = state == ST_ADDR && req_q.write && !aw_done;
    assign wvalid    = state == ST_ADDR && req_q.write && !w_done;
    assign arvalid   = state == ST_ADDR && !req_q.write;
    assign bready    = state == ST_WAIT && req_q.write;
    assign rready    = state == ST_WAIT && !req_q.write;
    assign aw.addr   = req_q.addr;
    assign ar.addr   = req_q.addr;
    assign w.data    = req_q.wdata;
    assign w.strb    = req_q.strb;

endmodule

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              fetch_req_valid,
    input  bus_pkg::bus_req_t fetch_req,
    output logic              fetch_req_ready,
    output logic              fetch_rsp_valid,
    output bus_pkg::bus_rsp_t fetch_rsp,
    input  logic              fetch_rsp_ready,
    input  logic              lsu_req_valid,
    input  bus_pkg::bus_req_t lsu_req,
    output logic              lsu_req_ready,
    output logic              lsu_rsp_valid,
    output bus_pkg::bus_rsp_t lsu_rsp,
    input  logic              lsu_rsp_ready,
    output logic              req_valid,
    output bus_pkg::bus_req_t req,
    input  logic              req_ready,
    input  logic              rsp_valid,
    input  bus_pkg::bus_rsp_t rsp,
    output logic              rsp_ready
);
    import bus_pkg::*;

    bus_req_t req_q;        // Winning request
    logic     busy;         // Transaction outstanding
    logic     issued;       // Request already taken downstream
    logic     owner_lsu;    // Owner of the grant and last winner
    logic     fetch_take;
    logic     lsu_take;

    // On a tie the requester not served last gets the grant
    assign fetch_req_ready = !busy && (!lsu_req_valid || owner_lsu);
    assign lsu_req_ready   = !busy && (!fetch_req_valid || !owner_lsu);
    assign fetch_take      = fetch_req_valid && fetch_req_ready;
    assign lsu_take        = lsu_req_valid && lsu_req_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            issued    <= 1'b0;
            owner_lsu <= 1'b1;          // Fetch wins the first tie
        end else if (busy) begin
            if (req_valid && req_ready) begin
                issued <= 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                busy <= 1'b0;           // Grant ends on response handshake
            end
        end else if (fetch_take || lsu_take) begin
            busy      <= 1'b1;
            issued    <= 1'b0;
            owner_lsu <= lsu_take;
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_take) begin
            req_q       <= fetch_req;
            req_q.write <= 1'b0;        // Fetch is read only
        end else if (lsu_take) begin
            req_q <= lsu_req;
        end
    end

    assign req_valid       = busy && !issued;   // Forwarded once
    assign req             = req_q;
    assign fetch_rsp_valid = rsp_valid && !owner_lsu;
    assign lsu_rsp_valid   = rsp_valid && owner_lsu;
    assign fetch_rsp       = rsp;
    assign lsu_rsp         = rsp;
    assign rsp_ready       = busy && (owner_lsu ? lsu_rsp_ready : fetch_rsp_ready);

endmodule

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 32;             // Byte address
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;     // One strobe per byte lane
    localparam int RESP_W = 2;

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // Address is in the CLINT window when (addr & MASK) == BASE
    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] CLINT_MASK = 32'hFFFF_0000;

    localparam logic [15:0] MSIP_OFS        = 16'h0000; // Software interrupt pending
    localparam logic [15:0] MTIMECMP_LO_OFS = 16'h4000;
    localparam logic [15:0] MTIMECMP_HI_OFS = 16'h4004;
    localparam logic [15:0] MTIME_LO_OFS    = 16'hBFF8; // Free-running timer
    localparam logic [15:0] MTIME_HI_OFS    = 16'hBFFC;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic              write;           // Store when set
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;           // Zero for stores
        logic [RESP_W-1:0] resp;
    } bus_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
    } axi_r_t;

endpackage

`default_nettype wire

// ==== rtl/bus_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_router (
    input  logic              req_valid,
    input  bus_pkg::bus_req_t req,
    output logic              req_ready,
    output logic              rsp_valid,
    output bus_pkg::bus_rsp_t rsp,
    input  logic              rsp_ready,
    output logic              clint_req_valid,
    output bus_pkg::bus_req_t clint_req,
    input  logic              clint_req_ready,
    input  logic              clint_rsp_valid,
    input  bus_pkg::bus_rsp_t clint_rsp,
    output logic              clint_rsp_ready,
    output logic              ext_req_valid,
    output bus_pkg::bus_req_t ext_req,
    input  logic              ext_req_ready,
    input  logic              ext_rsp_valid,
    input  bus_pkg::bus_rsp_t ext_rsp,
    output logic              ext_rsp_ready
);
    import bus_pkg::*;

    logic hit_clint;    // Target of the current request

    // Request is held by the arbiter until its response, so the decode stays put
    assign hit_clint = (req.addr & CLINT_MASK) == CLINT_BASE;

    assign clint_req_valid = req_valid && hit_clint;
    assign ext_req_valid   = req_valid && !hit_clint;   // Everything else goes out
    assign clint_req       = req;
    assign ext_req         = req;
    assign req_ready       = hit_clint ? clint_req_ready : ext_req_ready;

    assign rsp_valid       = hit_clint ? clint_rsp_valid : ext_rsp_valid;
    assign rsp             = hit_clint ? clint_rsp : ext_rsp;
    assign clint_rsp_ready = rsp_ready && hit_clint;
    assign ext_rsp_ready   = rsp_ready && !hit_clint;

endmodule

`default_nettype wire

// ==== rtl/clint.sv ====
`timescale 1ns/1ns
`default_nettype none

module clint (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              req_valid,
    input  bus_pkg::bus_req_t req,
    output logic              req_ready,
    output logic              rsp_valid,
    output bus_pkg::bus_rsp_t rsp,
    input  logic              rsp_ready,
    output logic              soft_irq,
    output logic              timer_irq
);
    import bus_pkg::*;

    logic [63:0]       mtime;
    logic [63:0]       mtimecmp;
    logic              msip;
    logic [15:0]       ofs;         // Offset inside the window
    logic              take;
    logic              wr;
    logic              hit;         // Offset is mapped
    logic [DATA_W-1:0] rd_data;

    // Byte-lane merge under the write strobes
    function automatic logic [DATA_W-1:0] merge(
        input logic [DATA_W-1:0] old,
        input logic [DATA_W-1:0] din,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] res;
        res = old;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = din[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign ofs       = req.addr[15:0];
    assign req_ready = !rsp_valid;          // One transaction at a time
    assign take      = req_valid && req_ready;
    assign wr        = take && req.write;

    always_comb begin
        hit     = 1'b1;
        rd_data = '0;
        case (ofs)
            MSIP_OFS:        rd_data = {{(DATA_W-1){1'b0}}, msip};
            MTIMECMP_LO_OFS: rd_data = mtimecmp[31:0];
            MTIMECMP_HI_OFS: rd_data = mtimecmp[63:32];
            MTIME_LO_OFS:    rd_data = mtime[31:0];
            MTIME_HI_OFS:    rd_data = mtime[63:32];
            default:         hit = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mtime    <= '0;
            mtimecmp <= '1;                 // No timer interrupt out of reset
            msip     <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;         // Write below overrides its half
            if (wr) begin
                case (ofs)
                    MSIP_OFS: begin
                        if (req.strb[0]) begin
                            msip <= req.wdata[0];
                        end
                    end
                    MTIMECMP_LO_OFS: mtimecmp[31:0]  <= merge(mtimecmp[31:0], req.wdata, req.strb);
                    MTIMECMP_HI_OFS: mtimecmp[63:32] <= merge(mtimecmp[63:32], req.wdata, req.strb);
                    MTIME_LO_OFS:    mtime[31:0]     <= merge(mtime[31:0], req.wdata, req.strb);
                    MTIME_HI_OFS:    mtime[63:32]    <= merge(mtime[63:32], req.wdata, req.strb);
                    default: ;                      // Unmapped write ignored
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (take) begin
            rsp_valid <= 1'b1;              // Cycle after accept
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            rsp.rdata <= (hit && !req.write) ? rd_data : '0;
            rsp.resp  <= hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign soft_irq  = msip;
    assign timer_irq = mtime >= mtimecmp;

endmodule

`default_nettype wire

// ==== rtl/core_interconnect.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_interconnect (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       fetch_req_valid,  // Instruction fetch
    input  bus_pkg::bus_req_t          fetch_req,
    output logic                       fetch_req_ready,
    output logic                       fetch_rsp_valid,
    output bus_pkg::bus_rsp_t          fetch_rsp,
    input  logic                       fetch_rsp_ready,
    input  logic                       lsu_req_valid,    // Load/store
    input  bus_pkg::bus_req_t          lsu_req,
    output logic                       lsu_req_ready,
    output logic                       lsu_rsp_valid,
    output bus_pkg::bus_rsp_t          lsu_rsp,
    input  logic                       lsu_rsp_ready,
    output logic                       awvalid,          // AXI-lite master
    output bus_pkg::axi_addr_t         aw,
    input  logic                       awready,
    output logic                       wvalid,
    output bus_pkg::axi_w_t            w,
    input  logic                       wready,
    input  logic                       bvalid,
    input  logic [bus_pkg::RESP_W-1:0] bresp,
    output logic                       bready,
    output logic                       arvalid,
    output bus_pkg::axi_addr_t         ar,
    input  logic                       arready,
    input  logic                       rvalid,
    input  bus_pkg::axi_r_t            r,
    output logic                       rready,
    output logic                       soft_irq,
    output logic                       timer_irq
);
    import bus_pkg::*;

    logic     req_valid;        // Granted request, arbiter to router
    bus_req_t req;
    logic     req_ready;
    logic     rsp_valid;
    bus_rsp_t rsp;
    logic     rsp_ready;
    logic     clint_req_valid;  // Router to CLINT
    bus_req_t clint_req;
    logic     clint_req_ready;
    logic     clint_rsp_valid;
    bus_rsp_t clint_rsp;
    logic     clint_rsp_ready;
    logic     ext_req_valid;    // Router to AXI master port
    bus_req_t ext_req;
    logic     ext_req_ready;
    logic     ext_rsp_valid;
    bus_rsp_t ext_rsp;
    logic     ext_rsp_ready;

    bus_arbiter bus_arbiter_u0 (.*);   // Names match one to one

    bus_router bus_router_u0 (.*);

    clint clint_u0 (
        .req_valid (clint_req_valid),
        .req       (clint_req),
        .req_ready (clint_req_ready),
        .rsp_valid (clint_rsp_valid),
        .rsp       (clint_rsp),
        .rsp_ready (clint_rsp_ready),
        .*                              // Clock, reset, interrupts
    );

    axi_master_port axi_master_port_u0 (
        .req_valid (ext_req_valid),
        .req       (ext_req),
        .req_ready (ext_req_ready),
        .rsp_valid (ext_rsp_valid),
        .rsp       (ext_rsp),
        .rsp_ready (ext_rsp_ready),
        .*                              // Clock, reset, AXI channels
    );

endmodule

`default_nettype wire

// ==== testbench/core_interconnect_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_interconnect_checker (
    input logic                       clock,
    input logic                       rst_n,
    input logic                       fetch_rsp_valid,
    input bus_pkg::bus_rsp_t          fetch_rsp,
    input logic                       fetch_rsp_ready,
    input logic                       lsu_rsp_valid,
    input bus_pkg::bus_rsp_t          lsu_rsp,
    input logic                       lsu_rsp_ready,
    input logic                       awvalid,
    input bus_pkg::axi_addr_t         aw,
    input logic                       awready,
    input logic                       wvalid,
    input bus_pkg::axi_w_t            w,
    input logic                       wready,
    input logic                       bready,
    input logic                       arvalid,
    input bus_pkg::axi_addr_t         ar,
    input logic                       arready,
    input logic                       rready,
    input logic                       soft_irq,
    input logic                       timer_irq
);

    fetch_rsp_hold: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_rsp_valid && !fetch_rsp_ready |=> fetch_rsp_valid && $stable(fetch_rsp))
        else $error("fetch response dropped or changed before handshake");

    lsu_rsp_hold: assert property (@(posedge clock) disable iff (!rst_n)
        lsu_rsp_valid && !lsu_rsp_ready |=> lsu_rsp_valid && $stable(lsu_rsp))
        else $error("lsu response dropped or changed before handshake");

    aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW dropped or changed before handshake");

    w_hold: assert property (@(posedge clock) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W dropped or changed before handshake");

    ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR dropped or changed before handshake");

    // Registers settle one edge into reset
    reset_quiet: assert property (@(posedge clock)
        !rst_n |=> !(fetch_rsp_valid || lsu_rsp_valid || awvalid || wvalid || arvalid
                     || bready || rready || soft_irq || timer_irq))
        else $error("valid or interrupt high during reset");

    rsp_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
        !(fetch_rsp_valid && lsu_rsp_valid))
        else $error("both responses valid together");

endmodule

bind core_interconnect core_interconnect_checker checker_u0 (.*);

`default_nettype wire

// ==== testbench/core_interconnect_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_interconnect_tb;
    import bus_pkg::*;

    localparam int TIMEOUT = 200;           // Cycles allowed per wait loop

    logic              clock;
    logic              rst_n;
    logic              fetch_req_valid;
    bus_req_t          fetch_req;
    logic              fetch_req_ready;
    logic              fetch_rsp_valid;
    bus_rsp_t          fetch_rsp;
    logic              fetch_rsp_ready;
    logic              lsu_req_valid;
    bus_req_t          lsu_req;
    logic              lsu_req_ready;
    logic              lsu_rsp_valid;
    bus_rsp_t          lsu_rsp;
    logic              lsu_rsp_ready;
    logic              awvalid;
    axi_addr_t         aw;
    logic              awready;
    logic              wvalid;
    axi_w_t            w;
    logic              wready;
    logic              bvalid;
    logic [RESP_W-1:0] bresp;
    logic              bready;
    logic              arvalid;
    axi_addr_t         ar;
    logic              arready;
    logic              rvalid;
    axi_r_t            r;
    logic              rready;
    logic              soft_irq;
    logic              timer_irq;

    integer            seed = 32'h7440;
    bus_req_t          cur_req;             // Request now on the bus
    logic [RESP_W-1:0] ext_resp;            // Last code sent by the memory model
    logic              sh_msip;             // Shadow CLINT
    logic [63:0]       sh_cmp;
    logic [31:0]       sh_mem [logic [31:0]];   // Shadow of external memory
    logic [31:0]       mem [logic [31:0]];      // Memory model storage
    logic              last_lsu;            // Requester granted last
    int                errors = 0;

    core_interconnect dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run(input string why);
        errors = errors + 1;
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_wdata(input string name, input axi_w_t got, input axi_w_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // Power-on content that differs for every address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic [31:0] apply_strb(input logic [31:0] old, input logic [31:0] din,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = din[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] clint_addr(input logic [15:0] ofs);
        return {CLINT_BASE[31:16], ofs};
    endfunction

    function automatic bus_req_t make_req(input logic [31:0] addr, input logic [31:0] wdata,
                                          input logic [3:0] strb, input logic write);
        bus_req_t rq;
        rq.addr  = addr;
        rq.wdata = wdata;
        rq.strb  = strb;
        rq.write = write;
        return rq;
    endfunction

    function automatic logic in_clint(input logic [31:0] addr);
        return (addr & CLINT_MASK) == CLINT_BASE;
    endfunction

    // Reference response from the shadow CLINT and memory
    function automatic bus_rsp_t expected_rsp(input bus_req_t rq, input logic is_fetch);
        bus_rsp_t e;
        logic     wr;
        wr      = rq.write && !is_fetch;    // Fetch never writes
        e.rdata = '0;
        e.resp  = RESP_OKAY;
        if (in_clint(rq.addr)) begin
            case (rq.addr[15:0])
                MSIP_OFS:        e.rdata = {31'd0, sh_msip};
                MTIMECMP_LO_OFS: e.rdata = sh_cmp[31:0];
                MTIMECMP_HI_OFS: e.rdata = sh_cmp[63:32];
                MTIME_LO_OFS, MTIME_HI_OFS: e.rdata = '0;  // Running value not predicted
                default:         e.resp = RESP_SLVERR;
            endcase
            if (wr) e.rdata = '0;
        end else begin
            e.resp = ext_resp;
            if (!wr) e.rdata = sh_mem.exists(rq.addr) ? sh_mem[rq.addr] : fill_word(rq.addr);
        end
        return e;
    endfunction

    task automatic update_shadow(input bus_req_t rq, input logic is_fetch);
        logic [31:0] old;
        if (rq.write && !is_fetch) begin
            if (!in_clint(rq.addr)) begin
                old = sh_mem.exists(rq.addr) ? sh_mem[rq.addr] : fill_word(rq.addr);
                sh_mem[rq.addr] = apply_strb(old, rq.wdata, rq.strb);
            end else if (rq.addr[15:0] == MSIP_OFS && rq.strb[0]) begin
                sh_msip = rq.wdata[0];
            end else if (rq.addr[15:0] == MTIMECMP_LO_OFS) begin
                sh_cmp[31:0] = apply_strb(sh_cmp[31:0], rq.wdata, rq.strb);
            end else if (rq.addr[15:0] == MTIMECMP_HI_OFS) begin
                sh_cmp[63:32] = apply_strb(sh_cmp[63:32], rq.wdata, rq.strb);
            end
        end
    endtask

    // Runs one transaction for a requester with optional response back-pressure
    task automatic issue(input logic lsu, input bus_req_t rq, input logic bp,
                         output bus_rsp_t got);
        int          n;
        logic        ok;
        logic        other_valid;
        logic        mtime_rd;
        logic [31:0] rnd;
        bus_rsp_t    exp;
        @(posedge clock);
        #1;
        if (lsu) begin
            lsu_req       = rq;
            lsu_req_valid = 1'b1;
        end else begin
            fetch_req       = rq;
            fetch_req_valid = 1'b1;
        end
        n  = 0;
        ok = 1'b0;
        while (!ok) begin
            @(posedge clock);
            ok = lsu ? lsu_req_ready : fetch_req_ready;
            n  = n + 1;
            if (!ok && n > TIMEOUT) abort_run("request was never accepted");
        end
        other_valid = lsu ? fetch_req_valid : lsu_req_valid;
        if (other_valid && lsu == last_lsu) begin
            abort_run("tie was granted to the requester served last");
        end
        last_lsu      = lsu;
        cur_req       = rq;
        cur_req.write = rq.write && lsu;
        n  = 0;
        ok = 1'b0;
        while (!ok) begin
            #1;
            rnd = $random(seed);
            if (lsu) begin
                lsu_req_valid = 1'b0;
                lsu_rsp_ready = !bp || rnd[0];
            end else begin
                fetch_req_valid = 1'b0;
                fetch_rsp_ready = !bp || rnd[0];
            end
            @(posedge clock);
            if (lsu ? fetch_req_ready : lsu_req_ready) begin
                abort_run("request accepted while a transaction was outstanding");
            end
            ok  = lsu ? (lsu_rsp_valid && lsu_rsp_ready) : (fetch_rsp_valid && fetch_rsp_ready);
            got = lsu ? lsu_rsp : fetch_rsp;
            n   = n + 1;
            if (!ok && n > TIMEOUT) abort_run("response never arrived");
        end
        exp      = expected_rsp(rq, !lsu);
        mtime_rd = in_clint(rq.addr) && !cur_req.write
                   && (rq.addr[15:0] == MTIME_LO_OFS || rq.addr[15:0] == MTIME_HI_OFS);
        if (mtime_rd) begin
            if (got.resp !== RESP_OKAY) abort_run("mtime read did not return OKAY");
        end else begin
            check_rsp(lsu ? "lsu_rsp" : "fetch_rsp", got, exp);
        end
        update_shadow(rq, !lsu);
    endtask

    task automatic random_delay();
        logic [31:0] rnd;
        rnd = $random(seed);
        repeat (rnd[1:0]) @(posedge clock);
        #1;
    endtask

    // External AXI-lite memory
    initial begin : memory_model
        int          n;
        logic [31:0] rnd;
        axi_w_t      wd;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = '0;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever begin
            @(posedge clock);
            if (arvalid) begin
                check_addr("ar", ar, cur_req.addr);
                random_delay();
                arready = 1'b1;
                @(posedge clock);
                #1 arready = 1'b0;
                random_delay();
                rnd      = $random(seed);
                ext_resp = rnd[0] ? RESP_SLVERR : RESP_OKAY;
                r.data   = mem.exists(cur_req.addr) ? mem[cur_req.addr] : fill_word(cur_req.addr);
                r.resp   = ext_resp;
                rvalid   = 1'b1;
                n = 0;
                do begin
                    @(posedge clock);
                    n = n + 1;
                    if (n > TIMEOUT) abort_run("rready never came");
                end while (!rready);
                #1 rvalid = 1'b0;
            end else if (awvalid || wvalid) begin
                if (!(awvalid && wvalid)) abort_run("AW and W were not raised together");
                check_addr("aw", aw, cur_req.addr);
                check_wdata("w", w, {cur_req.wdata, cur_req.strb});
                wd = w;
                random_delay();
                awready = 1'b1;
                wready  = 1'b1;
                @(posedge clock);
                #1;
                awready = 1'b0;
                wready  = 1'b0;
                mem[cur_req.addr] = apply_strb(mem.exists(cur_req.addr) ? mem[cur_req.addr]
                                               : fill_word(cur_req.addr), wd.data, wd.strb);
                random_delay();
                rnd      = $random(seed);
                ext_resp = rnd[0] ? RESP_SLVERR : RESP_OKAY;
                bresp    = ext_resp;
                bvalid   = 1'b1;
                n = 0;
                do begin
                    @(posedge clock);
                    n = n + 1;
                    if (n > TIMEOUT) abort_run("bready never came");
                end while (!bready);
                #1 bvalid = 1'b0;
            end
        end
    end

    initial begin : stimulus
        bus_rsp_t    g0;
        bus_rsp_t    g1;
        logic [31:0] rnd;
        logic [31:0] t;
        int          n;
        fetch_req_valid = 1'b0;
        fetch_req       = '0;
        fetch_rsp_ready = 1'b1;
        lsu_req_valid   = 1'b0;
        lsu_req         = '0;
        lsu_rsp_ready   = 1'b1;
        sh_msip         = 1'b0;
        sh_cmp          = '1;
        ext_resp        = RESP_OKAY;
        last_lsu        = 1'b1;
        rst_n           = 1'b0;
        repeat (16) @(posedge clock);
        #1 rst_n = 1'b1;

        issue(1'b1, make_req(clint_addr(MSIP_OFS), 32'h1, 4'hF, 1'b1), 1'b0, g0);
        if (soft_irq !== 1'b1) abort_run("soft_irq did not rise after msip write");
        issue(1'b1, make_req(clint_addr(MSIP_OFS), '0, '0, 1'b0), 1'b0, g0);
        issue(1'b1, make_req(clint_addr(MTIMECMP_LO_OFS), 32'hDEAD_BEEF, 4'h3, 1'b1), 1'b0, g0);
        issue(1'b1, make_req(clint_addr(MTIMECMP_HI_OFS), 32'h0, 4'hF, 1'b1), 1'b0, g0);
        issue(1'b1, make_req(clint_addr(MTIMECMP_LO_OFS), '0, '0, 1'b0), 1'b0, g0);
        issue(1'b0, make_req(clint_addr(MTIMECMP_HI_OFS), '0, '0, 1'b0), 1'b0, g0);

        issue(1'b1, make_req(32'h8000_0010, 32'h1357_9BDF, 4'hF, 1'b1), 1'b0, g0);
        issue(1'b0, make_req(32'h8000_0010, '0, '0, 1'b1), 1'b0, g0);   // Write flag ignored
        issue(1'b0, make_req(32'h8000_0100, '0, '0, 1'b0), 1'b0, g0);
        issue(1'b1, make_req(clint_addr(16'h1234), '0, '0, 1'b0), 1'b0, g0);
        issue(1'b1, make_req(clint_addr(16'h1234), 32'hFFFF_FFFF, 4'hF, 1'b1), 1'b0, g0);

        issue(1'b1, make_req(clint_addr(MTIME_LO_OFS), '0, '0, 1'b0), 1'b0, g0);
        t = g0.rdata + 32'd40;
        issue(1'b1, make_req(clint_addr(MTIMECMP_LO_OFS), t, 4'hF, 1'b1), 1'b0, g0);
        if (timer_irq !== 1'b0) abort_run("timer_irq high right after mtimecmp write");
        n = 0;
        while (!timer_irq) begin
            @(posedge clock);
            n = n + 1;
            if (n > 60) abort_run("timer_irq did not rise");
        end

        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            fork
                issue(1'b0, make_req({20'h80000, rnd[9:0], 2'b00}, '0, '0, 1'b0),
                      i >= 20, g0);
                issue(1'b1, make_req(rnd[12] ? clint_addr(MSIP_OFS)
                                     : {20'h80000, rnd[25:16], 2'b00},
                                     $random(seed), rnd[31:28], rnd[13]), i >= 20, g1);
            join
        end

        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
